// File: flist.f
src/rng_ctrl_pkg.sv
src/rng_data_pkg.sv
src/key_conditioner.sv
src/roll_controller.sv
src/lcg_generator.sv
src/save_slot.sv
src/hex_display.sv
src/rng_top.sv
tests/tb_rng_top.sv

// File: tests/tb_rng_top.sv
`timescale 1ns/1ps

module tb_rng_top
	import rng_ctrl_pkg::*;
	import rng_data_pkg::*;
;

	localparam int DEBOUNCE_CYCLES = 3;
	localparam int FAST_STEP       = 2;
	localparam int MEDIUM_STEP     = 4;
	localparam int SLOW_STEP       = 8;
	localparam int FAST_LEN        = 32;
	localparam int MEDIUM_LEN      = 64;
	localparam int SLOW_LEN        = 128;
	localparam int TIMER_W         = 8;
	localparam int ROUNDS          = 2;
	localparam int MARGIN          = 1000;
	localparam int TIMEOUT_CYCLES  = (FAST_LEN + MEDIUM_LEN + SLOW_LEN) * ROUNDS + MARGIN;
	localparam int DRIVE_DELAY     = 1;
	localparam int KEY_START       = 0;
	localparam int KEY_STOP        = 1;
	localparam int KEY_SAVE        = 2;
	localparam logic [3:0]  RESET_VALUE = 4'd9;
	localparam logic [31:0] RAND_SEED   = 32'he8f102bf;

	logic         i_clk;
	logic         i_rst_n;
	logic         i_key_start;
	logic         i_key_stop;
	logic         i_key_save;
	seg_pattern_t o_seg_random;
	seg_pattern_t o_seg_saved;
	phase_t       o_phase;

	// compare process state
	phase_t       ph_d1 = PH_IDLE;
	phase_t       ph_d2 = PH_IDLE;
	phase_t       ph_d3 = PH_IDLE;
	phase_t       resume_ref = PH_FAST;
	phase_t       exp_phase;
	lcg_value_t   cur_val = RESET_VALUE;
	seg_pattern_t last_seg;
	seg_pattern_t exp_saved;
	int           step_cnt [4];
	int           errors = 0;
	int           cycle_cnt = 0;
	logic [31:0]  rnd;

	rng_top #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
		.FAST_LEN       (FAST_LEN),
		.MEDIUM_LEN     (MEDIUM_LEN),
		.SLOW_LEN       (SLOW_LEN),
		.FAST_STEP      (FAST_STEP),
		.MEDIUM_STEP    (MEDIUM_STEP),
		.SLOW_STEP      (SLOW_STEP),
		.TIMER_W        (TIMER_W)
	) DUT (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_key_start (i_key_start),
		.i_key_stop  (i_key_stop),
		.i_key_save  (i_key_save),
		.o_seg_random(o_seg_random),
		.o_seg_saved (o_seg_saved),
		.o_phase     (o_phase)
	);

	function automatic lcg_value_t lcg_ref(input lcg_value_t v);
		return lcg_value_t'((11 * int'(v) + 29) % 16);
	endfunction

	// active low, gfedcba
	function automatic seg_pattern_t seg_ref(input lcg_value_t v);
		seg_pattern_t table_seg [16];
		table_seg = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
			7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};
		return table_seg[v];
	endfunction

	function automatic seg_pattern_t blank_ref();
		return 7'h7f;
	endfunction

	// inverse of the decode, used to pick up the seed
	function automatic lcg_value_t digit_of(input seg_pattern_t seg);
		lcg_value_t found;
		found = '0;
		for (int v = 0; v < 16; v++) begin
			if (seg_ref(lcg_value_t'(v)) == seg) begin
				found = lcg_value_t'(v);
			end
		end
		return found;
	endfunction

	function automatic int step_limit(input phase_t ph);
		case (ph)
			PH_FAST:   return FAST_LEN / FAST_STEP;
			PH_MEDIUM: return MEDIUM_LEN / MEDIUM_STEP;
			PH_SLOW:   return SLOW_LEN / SLOW_STEP;
			default:   return 0;
		endcase
	endfunction

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Error at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
			$display("Finished with errors");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic drive_slot();
		@(posedge i_clk);
		#DRIVE_DELAY;
	endtask

	task automatic press_key(input int which);
		int hold;
		int gap;
		hold = 5 + ($urandom % 6);
		gap  = 5 + ($urandom % 6);
		case (which)
			KEY_START: i_key_start = 1'b1;
			KEY_STOP:  i_key_stop  = 1'b1;
			default:   i_key_save  = 1'b1;
		endcase
		repeat (hold) drive_slot();
		i_key_start = 1'b0;
		i_key_stop  = 1'b0;
		i_key_save  = 1'b0;
		repeat (gap) drive_slot();
	endtask

	task automatic wait_phase(input phase_t target);
		while (o_phase != target) begin
			drive_slot();
		end
	endtask

	// one roll with a stop, save and resume in the given phase, then a recall
	task automatic run_roll(input phase_t stop_in);
		press_key(KEY_START);
		wait_phase(stop_in);
		repeat (4) drive_slot();
		press_key(KEY_STOP);
		wait_phase(PH_STOPPED);
		repeat (4) drive_slot();
		exp_saved = seg_ref(cur_val);
		press_key(KEY_SAVE);
		repeat (6) drive_slot();
		press_key(KEY_STOP);
		while (o_phase == PH_STOPPED) begin
			drive_slot();
		end
		wait_phase(PH_FINAL);
		press_key(KEY_START);
		wait_phase(PH_IDLE);
		press_key(KEY_SAVE);
		check_equal(o_seg_saved, exp_saved, "recalled digit");
	endtask

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("Finished with errors");
			$fatal(1, "timeout");
		end
	end

	// digit changes show up three samples after the phase that caused them
	always @(negedge i_clk) begin
		if (i_rst_n) begin
			if (o_phase != ph_d1) begin
				case (ph_d1)
					PH_IDLE:   exp_phase = PH_FAST;
					PH_FAST:   exp_phase = (o_phase == PH_STOPPED) ? PH_STOPPED : PH_MEDIUM;
					PH_MEDIUM: exp_phase = (o_phase == PH_STOPPED) ? PH_STOPPED : PH_SLOW;
					PH_SLOW:   exp_phase = (o_phase == PH_STOPPED) ? PH_STOPPED : PH_FINAL;
					PH_STOPPED: exp_phase = resume_ref;
					default:   exp_phase = PH_IDLE;
				endcase
				check_equal(o_phase, exp_phase, "phase order");
				if (o_phase == PH_STOPPED) begin
					resume_ref = ph_d1;
				end
				if (ph_d1 == PH_IDLE) begin
					step_cnt = '{default: 0};
				end
			end
			if (o_seg_random != last_seg) begin
				case (ph_d3)
					PH_IDLE: begin
						// seed load, not checked against the rule
						cur_val = digit_of(o_seg_random);
						check_equal(ph_d2, PH_FAST, "digit change in idle without a start");
					end
					PH_FAST, PH_MEDIUM, PH_SLOW: begin
						cur_val = lcg_ref(cur_val);
						step_cnt[ph_d3]++;
						check_equal(step_cnt[ph_d3] <= step_limit(ph_d3), 1, "steps in phase");
					end
					default: begin
						check_equal(o_seg_random, last_seg, "random digit held while stopped");
					end
				endcase
			end
			check_equal(o_seg_random, seg_ref(cur_val), "random digit");
			if (ph_d2 != PH_IDLE) begin
				check_equal(o_seg_saved, blank_ref(), "saved digit blank while running");
			end else begin
				check_equal((o_seg_saved == blank_ref()) || (o_seg_saved == exp_saved), 1,
					"saved digit in idle");
			end
			ph_d3    = ph_d2;
			ph_d2    = ph_d1;
			ph_d1    = o_phase;
			last_seg = o_seg_random;
		end
	end

	initial begin
		i_rst_n     = 1'b0;
		i_key_start = 1'b0;
		i_key_stop  = 1'b0;
		i_key_save  = 1'b0;
		exp_saved   = 7'h7f;
		last_seg    = seg_ref(RESET_VALUE);
		step_cnt    = '{default: 0};
		rnd         = $urandom(RAND_SEED);
		repeat (2) @(posedge i_clk);
		#DRIVE_DELAY;
		i_rst_n = 1'b1;
		drive_slot();
		check_equal(o_phase, PH_IDLE, "phase after reset");
		check_equal(o_seg_random, seg_ref(RESET_VALUE), "random digit after reset");
		check_equal(o_seg_saved, blank_ref(), "saved digit after reset");
		// recall before anything was saved
		press_key(KEY_SAVE);
		repeat (4) drive_slot();
		check_equal(o_seg_saved, blank_ref(), "saved digit after empty recall");
		run_roll(PH_FAST);
		run_roll(PH_SLOW);
		repeat (8) drive_slot();
		if (errors == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("Finished with errors");
			$fatal(1, "errors seen");
		end
	end

endmodule

// File: src/rng_top.sv
`timescale 1ns/1ps

module rng_top
	import rng_ctrl_pkg::*;
	import rng_data_pkg::*;
#(
	parameter int DEBOUNCE_CYCLES = 1_000_000,
	parameter int FAST_LEN        = 100_000_000,
	parameter int MEDIUM_LEN      = 100_000_000,
	parameter int SLOW_LEN        = 100_000_000,
	parameter int FAST_STEP       = 600_000,
	parameter int MEDIUM_STEP     = 2_000_000,
	parameter int SLOW_STEP       = 8_000_000,
	parameter int TIMER_W         = 30
) (
	input  logic         i_clk,
	input  logic         i_rst_n,
	input  logic         i_key_start,
	input  logic         i_key_stop,
	input  logic         i_key_save,
	output seg_pattern_t o_seg_random,
	output seg_pattern_t o_seg_saved,
	output phase_t       o_phase
);

	key_pulse_t  pulse;
	phase_t      phase;
	logic        step;
	logic        seed_load;
	lcg_value_t  seed;
	lcg_value_t  value;
	slot_entry_t shown;

	assign o_phase = phase;

	key_conditioner #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) u_key_conditioner (
		.i_clk  (i_clk),
		.i_rst_n(i_rst_n),
		.i_keys ({i_key_start, i_key_stop, i_key_save}),
		.o_pulse(pulse)
	);

	roll_controller #(
		.FAST_LEN   (FAST_LEN),
		.MEDIUM_LEN (MEDIUM_LEN),
		.SLOW_LEN   (SLOW_LEN),
		.FAST_STEP  (FAST_STEP),
		.MEDIUM_STEP(MEDIUM_STEP),
		.SLOW_STEP  (SLOW_STEP),
		.TIMER_W    (TIMER_W)
	) u_roll_controller (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_pulse    (pulse),
		.o_phase    (phase),
		.o_step     (step),
		.o_seed_load(seed_load),
		.o_seed     (seed)
	);

	lcg_generator u_lcg_generator (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_step     (step),
		.i_seed_load(seed_load),
		.i_seed     (seed),
		.o_value    (value)
	);

	save_slot u_save_slot (
		.i_clk  (i_clk),
		.i_rst_n(i_rst_n),
		.i_phase(phase),
		.i_save (pulse.save),
		.i_value(value),
		.o_shown(shown)
	);

	hex_display u_hex_display (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_value     (value),
		.i_shown     (shown),
		.o_seg_random(o_seg_random),
		.o_seg_saved (o_seg_saved)
	);

endmodule

// File: src/hex_display.sv
`timescale 1ns/1ps

module hex_display
	import rng_data_pkg::*;
(
	input  logic         i_clk,
	input  logic         i_rst_n,
	input  lcg_value_t   i_value,
	input  slot_entry_t  i_shown,
	output seg_pattern_t o_seg_random,
	output seg_pattern_t o_seg_saved
);

	localparam seg_pattern_t SEG_BLANK = 7'b111_1111;

	function automatic seg_pattern_t seg_decode(input lcg_value_t digit);
		seg_pattern_t seg;
		case (digit)
			4'h0: seg = 7'b100_0000;
			4'h1: seg = 7'b111_1001;
			4'h2: seg = 7'b010_0100;
			4'h3: seg = 7'b011_0000;
			4'h4: seg = 7'b001_1001;
			4'h5: seg = 7'b001_0010;
			4'h6: seg = 7'b000_0010;
			4'h7: seg = 7'b111_1000;
			4'h8: seg = 7'b000_0000;
			4'h9: seg = 7'b001_0000;
			// lower-case b and d keep them apart from 8 and 0
			4'ha: seg = 7'b000_1000;
			4'hb: seg = 7'b000_0011;
			4'hc: seg = 7'b100_0110;
			4'hd: seg = 7'b010_0001;
			4'he: seg = 7'b000_0110;
			default: seg = 7'b000_1110;
		endcase
		return seg;
	endfunction

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_seg_random <= seg_decode(LCG_RESET_SEED);
			o_seg_saved  <= SEG_BLANK;
		end else begin
			o_seg_random <= seg_decode(i_value);
			o_seg_saved  <= i_shown.empty ? SEG_BLANK : seg_decode(i_shown.value);
		end
	end

endmodule

// File: src/save_slot.sv
`timescale 1ns/1ps

module save_slot
	import rng_ctrl_pkg::*;
	import rng_data_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  phase_t      i_phase,
	input  logic        i_save,
	input  lcg_value_t  i_value,
	output slot_entry_t o_shown
);

	localparam slot_entry_t SLOT_EMPTY = '{empty: 1'b1, value: '0};

	slot_entry_t stored_q;
	slot_entry_t shown_q;
	logic        can_write;

	assign o_shown   = shown_q;
	assign can_write = (i_phase == PH_STOPPED) || (i_phase == PH_FINAL);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			stored_q <= SLOT_EMPTY;
			shown_q  <= SLOT_EMPTY;
		end else begin
			if (i_save && can_write) begin
				stored_q <= '{empty: 1'b0, value: i_value};
			end
			// recall only in idle, blank everywhere else
			if (i_phase != PH_IDLE) begin
				shown_q <= SLOT_EMPTY;
			end else if (i_save) begin
				shown_q <= stored_q;
			end
		end
	end

endmodule

// File: src/lcg_generator.sv
`timescale 1ns/1ps

module lcg_generator
	import rng_data_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_step,
	input  logic       i_seed_load,
	input  lcg_value_t i_seed,
	output lcg_value_t o_value
);

	lcg_value_t value_q;
	lcg_value_t lcg_next;
	logic [9:0] lcg_full;

	assign o_value = value_q;

	always_comb begin
		lcg_full = LCG_MUL * value_q + LCG_INC;
		// mod 16 is just the low nibble
		lcg_next = lcg_full[3:0];
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			value_q <= LCG_RESET_SEED;
		end else if (i_seed_load) begin
			value_q <= i_seed;
		end else if (i_step) begin
			value_q <= lcg_next;
		end
	end

endmodule

// File: src/roll_controller.sv
`timescale 1ns/1ps

module roll_controller
	import rng_ctrl_pkg::*;
	import rng_data_pkg::*;
#(
	parameter int FAST_LEN    = 100_000_000,
	parameter int MEDIUM_LEN  = 100_000_000,
	parameter int SLOW_LEN    = 100_000_000,
	parameter int FAST_STEP   = 600_000,
	parameter int MEDIUM_STEP = 2_000_000,
	parameter int SLOW_STEP   = 8_000_000,
	parameter int TIMER_W     = 30
) (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  key_pulse_t i_pulse,
	output phase_t     o_phase,
	output logic       o_step,
	output logic       o_seed_load,
	output lcg_value_t o_seed
);

	phase_t             phase_q;
	phase_t             phase_d;
	phase_t             resume_q;
	phase_t             resume_d;
	phase_t             next_run;
	logic [TIMER_W-1:0] timer_q;
	logic [TIMER_W-1:0] timer_d;
	logic [TIMER_W-1:0] timer_inc;
	lcg_value_t         seed_q;
	logic               len_hit;
	logic               step_due;
	logic               step_d;
	logic               seed_load_d;

	assign o_phase = phase_q;
	assign o_seed  = seed_q;

	// per-phase length, step period and successor
	always_comb begin
		timer_inc = timer_q + 1'b1;
		len_hit   = 1'b0;
		step_due  = 1'b0;
		next_run  = PH_FINAL;
		case (phase_q)
			PH_FAST: begin
				len_hit  = (timer_inc == TIMER_W'(FAST_LEN));
				step_due = ((timer_inc % TIMER_W'(FAST_STEP)) == '0);
				next_run = PH_MEDIUM;
			end
			PH_MEDIUM: begin
				len_hit  = (timer_inc == TIMER_W'(MEDIUM_LEN));
				step_due = ((timer_inc % TIMER_W'(MEDIUM_STEP)) == '0);
				next_run = PH_SLOW;
			end
			PH_SLOW: begin
				len_hit  = (timer_inc == TIMER_W'(SLOW_LEN));
				step_due = ((timer_inc % TIMER_W'(SLOW_STEP)) == '0);
				next_run = PH_FINAL;
			end
			default: begin
				len_hit  = 1'b0;
				step_due = 1'b0;
			end
		endcase
	end

	always_comb begin
		phase_d     = phase_q;
		resume_d    = resume_q;
		timer_d     = timer_q;
		step_d      = 1'b0;
		seed_load_d = 1'b0;
		case (phase_q)
			PH_IDLE: begin
				if (i_pulse.start) begin
					phase_d     = PH_FAST;
					timer_d     = '0;
					seed_load_d = 1'b1;
				end
			end
			PH_FAST, PH_MEDIUM, PH_SLOW: begin
				if (i_pulse.stop) begin
					// timer is kept so the phase picks up where it left
					phase_d  = PH_STOPPED;
					resume_d = phase_q;
				end else begin
					step_d = step_due;
					if (len_hit) begin
						phase_d = next_run;
						timer_d = '0;
					end else begin
						timer_d = timer_inc;
					end
				end
			end
			PH_STOPPED: begin
				if (i_pulse.stop) begin
					phase_d = resume_q;
				end
			end
			PH_FINAL: begin
				if (i_pulse.start) begin
					phase_d = PH_IDLE;
					timer_d = '0;
				end
			end
			default: begin
				phase_d = PH_IDLE;
				timer_d = '0;
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			phase_q     <= PH_IDLE;
			resume_q    <= PH_FAST;
			timer_q     <= '0;
			seed_q      <= '0;
			o_step      <= 1'b0;
			o_seed_load <= 1'b0;
		end else begin
			phase_q     <= phase_d;
			resume_q    <= resume_d;
			timer_q     <= timer_d;
			o_step      <= step_d;
			o_seed_load <= seed_load_d;
			// seed depends on how long the user waits in idle
			if (phase_q == PH_IDLE) begin
				seed_q <= seed_q + 1'b1;
			end
		end
	end

endmodule

// File: src/key_conditioner.sv
`timescale 1ns/1ps

module key_conditioner
	import rng_ctrl_pkg::*;
#(
	parameter int DEBOUNCE_CYCLES = 1_000_000
) (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic [2:0] i_keys,
	output key_pulse_t o_pulse
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic [2:0]       sync_a;
	logic [2:0]       sync_b;
	logic [2:0]       level;
	logic [2:0]       press;
	logic [CNT_W-1:0] stable_cnt [3];

	// bit order follows key_pulse_t: start, stop, save
	assign o_pulse = key_pulse_t'(press);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sync_a <= '0;
			sync_b <= '0;
			level  <= '0;
			press  <= '0;
			for (int k = 0; k < 3; k++) begin
				stable_cnt[k] <= '0;
			end
		end else begin
			sync_a <= i_keys;
			sync_b <= sync_a;
			for (int k = 0; k < 3; k++) begin
				press[k] <= 1'b0;
				if (sync_b[k] == level[k]) begin
					// bounce, start over
					stable_cnt[k] <= '0;
				end else if (stable_cnt[k] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
					stable_cnt[k] <= '0;
					level[k]      <= sync_b[k];
					// only the press edge makes a pulse
					press[k]      <= sync_b[k];
				end else begin
					stable_cnt[k] <= stable_cnt[k] + 1'b1;
				end
			end
		end
	end

endmodule

// File: src/rng_data_pkg.sv
package rng_data_pkg;

	typedef logic [3:0] lcg_value_t;

	// active low, bit 6 is segment g and bit 0 is segment a
	typedef logic [6:0] seg_pattern_t;

	typedef struct packed {
		logic       empty;
		lcg_value_t value;
	} slot_entry_t;

	// next = (LCG_MUL * value + LCG_INC) mod 16
	localparam logic [4:0] LCG_MUL = 5'd11;
	localparam logic [4:0] LCG_INC = 5'd29;

	localparam lcg_value_t LCG_RESET_SEED = 4'd9;

endpackage

// File: src/rng_ctrl_pkg.sv
package rng_ctrl_pkg;

	// roll phases, stopped and final sit after the running ones
	typedef enum logic [2:0] {
		PH_IDLE    = 3'd0,
		PH_FAST    = 3'd1,
		PH_MEDIUM  = 3'd2,
		PH_SLOW    = 3'd3,
		PH_STOPPED = 3'd4,
		PH_FINAL   = 3'd5
	} phase_t;

	// one-cycle key presses after debouncing
	typedef struct packed {
		logic start;
		logic stop;
		logic save;
	} key_pulse_t;

endpackage
